// ==== tb/gat_cases.txt ====
# name a0..a7 nodes mode; a0..a3 source half, a4..a7 destination half; mode steady or burst
# then one line per node row with lanes 0..3 (first row is the target), then expected lanes 0..3
single_node 1 2 3 4 5 6 7 8 1 steady
10 20 30 40
620 1240 1860 2480
multi_positive 2 1 0 1 1 1 1 1 3 steady
16 32 8 4
4 8 12 16
20 0 10 5
272 304 196 158
negative_scores -4 3 -2 1 -8 -6 5 -3 4 steady
100 50 -20 10
1000 800 -500 200
2000 1500 -1000 0
-7 3 1 -1
-383186 -293406 191238 -25318
upper_clamp 100 100 100 100 50 50 50 50 2 burst
100 100 100 100
1 2 3 -4
12827 12954 13081 12192
burst_eight 1 1 1 1 1 -1 1 -1 8 burst
64 32 16 8
10 0 10 0
0 10 0 10
50 0 0 0
0 0 0 100
0 100 0 0
0 200 0 0
30 20 10 5
1460 440 320 280
rewritten_a 0 0 0 0 16 16 16 16 2 steady
1 2 3 4
8 8 8 8
266 276 286 296

// ==== project.f ====
rtl/gat_dims_pkg.sv
rtl/gat_fixed_pkg.sv
rtl/attn_score_unit.sv
rtl/coef_fifo.sv
rtl/feature_aggregator.sv
rtl/gat_attention_core.sv
tb/clk_rst_gen.sv
tb/gat_attention_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gat_attention_core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/gat_attention_core_tb.sv ====
`timescale 1ns/1ps

module gat_attention_core_tb;

  import gat_dims_pkg::*;

  localparam int MAX_NODES    = 8;
  localparam int RST_TIMEOUT  = 20;
  localparam int RDY_TIMEOUT  = 100;
  localparam int FEAT_TIMEOUT = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  wh_vld_i;
  logic                  wh_last_i;
  logic [WH_ROW_W-1:0]   wh_data_i;
  logic                  wh_rdy_o;
  logic                  a_wr_i;
  logic [A_ADDR_W-1:0]   a_addr_i;
  logic [A_W-1:0]        a_data_i;
  logic                  feat_vld_o;
  logic [FEAT_ROW_W-1:0] feat_data_o;

  int           fd;
  int           errors;
  int           cases_run;
  int           cases_failed;
  bit           timed_out;
  bit           rdy_dropped;
  logic [31:0]  rng_state;

  // Case being run
  logic [127:0] cur_name;
  logic [127:0] cur_mode;
  int           cur_nodes;
  int           cur_a [A_DEPTH];
  int           cur_rows [MAX_NODES][NUM_FEAT];
  int           cur_exp [NUM_FEAT];

  clk_rst_gen u_clk_rst (
    .clk   (clk  ),
    .rst_n (rst_n)
  );

  gat_attention_core u_dut (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .wh_vld_i    (wh_vld_i   ),
    .wh_last_i   (wh_last_i  ),
    .wh_data_i   (wh_data_i  ),
    .wh_rdy_o    (wh_rdy_o   ),
    .a_wr_i      (a_wr_i     ),
    .a_addr_i    (a_addr_i   ),
    .a_data_i    (a_data_i   ),
    .feat_vld_o  (feat_vld_o ),
    .feat_data_o (feat_data_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(input string sig, input longint expected, input longint actual);
    assert (expected == actual) else begin
      $display("FAIL t=%0t %s expected %0d got %0d", $time, sig, expected, actual);
      errors++;
    end
  endtask

  // Skips comment and blank lines
  task automatic next_line(output string s, output bit ok);
    int code;
    ok = 1'b0;
    s = "";
    while (!ok && !$feof(fd)) begin
      code = $fgets(s, fd);
      if (code > 1 && s.getc(0) != "#") begin
        ok = 1'b1;
      end
    end
  endtask

  task automatic read_case(input string header, output bit ok);
    string line;
    int    fields;
    bit    got_line;
    ok = 1'b0;
    fields = $sscanf(header, "%s %d %d %d %d %d %d %d %d %d %s", cur_name,
                     cur_a[0], cur_a[1], cur_a[2], cur_a[3], cur_a[4], cur_a[5],
                     cur_a[6], cur_a[7], cur_nodes, cur_mode);
    if (fields != 11 || cur_nodes < 1 || cur_nodes > MAX_NODES) begin
      $display("case line could not be parsed: %s", header);
      return;
    end
    for (int j = 0; j < cur_nodes; j++) begin
      fields = 0;
      next_line(line, got_line);
      if (got_line) begin
        fields = $sscanf(line, "%d %d %d %d", cur_rows[j][0], cur_rows[j][1],
                         cur_rows[j][2], cur_rows[j][3]);
      end
      if (fields != NUM_FEAT) begin
        $display("row %0d of case %0s is missing or malformed", j, cur_name);
        return;
      end
    end
    fields = 0;
    next_line(line, got_line);
    if (got_line) begin
      fields = $sscanf(line, "%d %d %d %d", cur_exp[0], cur_exp[1], cur_exp[2], cur_exp[3]);
    end
    if (fields != NUM_FEAT) begin
      $display("expected lanes of case %0s are missing or malformed", cur_name);
      return;
    end
    ok = 1'b1;
  endtask

  task automatic check_reset();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 1) begin
        check_eq("feat_vld_o", 0, feat_vld_o);
        check_eq("wh_rdy_o", 1, wh_rdy_o);
      end
    end while (!rst_n && n < RST_TIMEOUT);
    assert (rst_n) else begin
      $display("reset was never released");
      timed_out = 1'b1;
      errors++;
    end
    @(posedge clk);
    check_eq("feat_vld_o", 0, feat_vld_o);
    check_eq("wh_rdy_o", 1, wh_rdy_o);
  endtask

  task automatic write_a();
    for (int i = 0; i < A_DEPTH; i++) begin
      a_wr_i   <= 1'b1;
      a_addr_i <= A_ADDR_W'(i);
      a_data_i <= A_W'(cur_a[i]);
      @(posedge clk);
    end
    a_wr_i <= 1'b0;
  endtask

  task automatic drive_rows();
    logic [WH_ROW_W-1:0] row;
    int                  gap;
    int                  waited;
    bit                  taken;
    for (int j = 0; j < cur_nodes && !timed_out; j++) begin
      if (cur_mode != "burst" && j > 0) begin
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[1:0]);
        wh_vld_i <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      for (int k = 0; k < NUM_FEAT; k++) begin
        row[k*WH_W +: WH_W] = WH_W'(cur_rows[j][k]);
      end
      wh_vld_i  <= 1'b1;
      wh_last_i <= (j == cur_nodes - 1);
      wh_data_i <= row;
      waited = 0;
      taken = 1'b0;
      // Row is taken on the edge where ready is seen high
      while (!taken && waited < RDY_TIMEOUT) begin
        @(posedge clk);
        waited++;
        taken = wh_rdy_o;
        if (!wh_rdy_o) begin
          rdy_dropped = 1'b1;
        end
      end
      assert (taken) else begin
        $display("%0t: row %0d of case %0s was never taken", $time, j, cur_name);
        timed_out = 1'b1;
        errors++;
      end
    end
    wh_vld_i  <= 1'b0;
    wh_last_i <= 1'b0;
  endtask

  task automatic wait_result(output logic [FEAT_ROW_W-1:0] data, output bit seen);
    int waited;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < FEAT_TIMEOUT) begin
      @(posedge clk);
      waited++;
      if (!wh_rdy_o) begin
        rdy_dropped = 1'b1;
      end
      if (feat_vld_o) begin
        seen = 1'b1;
        data = feat_data_o;
      end
    end
  endtask

  task automatic run_case(input string header);
    bit                       ok;
    bit                       seen;
    int                       errors_before;
    logic [FEAT_ROW_W-1:0]    got;
    logic signed [FEAT_W-1:0] lane;
    errors_before = errors;
    rdy_dropped = 1'b0;
    read_case(header, ok);
    assert (ok) else errors++;
    if (ok) begin
      write_a();
      drive_rows();
      if (!timed_out) begin
        wait_result(got, seen);
        assert (seen) else begin
          $display("%0t: no pulse on feat_vld_o for case %0s", $time, cur_name);
          timed_out = 1'b1;
          errors++;
        end
        if (seen) begin
          for (int k = 0; k < NUM_FEAT; k++) begin
            lane = got[k*FEAT_W +: FEAT_W];
            check_eq($sformatf("feat_data_o[%0d]", k), cur_exp[k], lane);
          end
        end
        if (cur_mode == "burst" && cur_nodes == MAX_NODES) begin
          assert (rdy_dropped) else begin
            $display("wh_rdy_o never dropped during the burst of case %0s", cur_name);
            errors++;
          end
        end
      end
    end
    cases_run++;
    if (errors != errors_before) begin
      cases_failed++;
    end
    $display("case %0s finished with %0d errors", cur_name, errors - errors_before);
  endtask

  initial begin
    string line;
    bit    more;
    wh_vld_i     = 1'b0;
    wh_last_i    = 1'b0;
    wh_data_i    = '0;
    a_wr_i       = 1'b0;
    a_addr_i     = '0;
    a_data_i     = '0;
    errors       = 0;
    cases_run    = 0;
    cases_failed = 0;
    timed_out    = 1'b0;
    rng_state    = 32'd3149;
    check_reset();
    if (!timed_out) begin
      fd = $fopen("tb/gat_cases.txt", "r");
      assert (fd != 0) else begin
        $display("case file tb/gat_cases.txt could not be opened");
        errors++;
      end
      if (fd != 0) begin
        more = 1'b1;
        while (more && !timed_out) begin
          next_line(line, more);
          if (more) begin
            run_case(line);
          end
        end
        $fclose(fd);
      end
    end
    assert (cases_run > 0) else begin
      $display("no case was run");
      errors++;
    end
    $display("cases run %0d, cases failed %0d, errors %0d", cases_run, cases_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== rtl/gat_attention_core.sv ====
`timescale 1ns/1ps

module gat_attention_core (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wh_vld_i,
  input  logic                                wh_last_i,
  input  logic [gat_dims_pkg::WH_ROW_W-1:0]   wh_data_i,
  output logic                                wh_rdy_o,
  input  logic                                a_wr_i,
  input  logic [gat_dims_pkg::A_ADDR_W-1:0]   a_addr_i,
  input  logic [gat_dims_pkg::A_W-1:0]        a_data_i,
  output logic                                feat_vld_o,
  output logic [gat_dims_pkg::FEAT_ROW_W-1:0] feat_data_o
);

  import gat_dims_pkg::*;

  logic               fifo_push;
  logic [ENTRY_W-1:0] fifo_push_entry;
  logic               fifo_pop;
  logic [ENTRY_W-1:0] fifo_pop_entry;
  logic               fifo_empty;
  logic               fifo_afull;

  // Rows are held outside while the FIFO reserve is in use
  assign wh_rdy_o = ~fifo_afull;

  attn_score_unit u_score (
    .clk          (clk            ),
    .rst_n        (rst_n          ),
    .wh_vld_i     (wh_vld_i       ),
    .wh_last_i    (wh_last_i      ),
    .wh_rdy_i     (wh_rdy_o       ),
    .wh_data_i    (wh_data_i      ),
    .a_wr_i       (a_wr_i         ),
    .a_addr_i     (a_addr_i       ),
    .a_data_i     (a_data_i       ),
    .push_o       (fifo_push      ),
    .push_entry_o (fifo_push_entry)
  );

  coef_fifo u_fifo (
    .clk          (clk            ),
    .rst_n        (rst_n          ),
    .push_i       (fifo_push      ),
    .push_entry_i (fifo_push_entry),
    .pop_i        (fifo_pop       ),
    .pop_entry_o  (fifo_pop_entry ),
    .empty_o      (fifo_empty     ),
    .afull_o      (fifo_afull     )
  );

  feature_aggregator u_aggr (
    .clk          (clk            ),
    .rst_n        (rst_n          ),
    .empty_i      (fifo_empty     ),
    .pop_entry_i  (fifo_pop_entry ),
    .pop_o        (fifo_pop       ),
    .feat_vld_o   (feat_vld_o     ),
    .feat_data_o  (feat_data_o    )
  );

endmodule

// ==== rtl/feature_aggregator.sv ====
`timescale 1ns/1ps

module feature_aggregator (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                empty_i,
  input  logic [gat_dims_pkg::ENTRY_W-1:0]    pop_entry_i,
  output logic                                pop_o,
  output logic                                feat_vld_o,
  output logic [gat_dims_pkg::FEAT_ROW_W-1:0] feat_data_o
);

  import gat_dims_pkg::*;

  logic [LANE_W-1:0]        lane_q;
  logic                     last_lane;
  logic                     entry_last;
  logic                     flush;
  logic signed [COEF_W-1:0] coef;
  logic signed [WH_W-1:0]   lane_val;
  logic signed [FEAT_W-1:0] prod;
  logic signed [FEAT_W-1:0] acc_q [NUM_FEAT];
  logic signed [FEAT_W-1:0] acc_d [NUM_FEAT];

  assign coef       = pop_entry_i[ENTRY_COEF_LSB +: COEF_W];
  assign entry_last = pop_entry_i[ENTRY_LAST_BIT];
  assign lane_val   = pop_entry_i[ENTRY_ROW_LSB + lane_q*WH_W +: WH_W];

  // Single shared multiplier steps one lane per cycle
  assign prod = coef * lane_val;

  assign last_lane = (lane_q == LANE_W'(NUM_FEAT - 1));
  assign pop_o     = ~empty_i & last_lane;
  assign flush     = pop_o & entry_last;

  always_comb begin
    for (int k = 0; k < NUM_FEAT; k++) begin
      acc_d[k] = acc_q[k];
    end
    if (!empty_i) begin
      acc_d[lane_q] = acc_q[lane_q] + prod;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_q     <= '0;
      feat_vld_o <= 1'b0;
      for (int k = 0; k < NUM_FEAT; k++) begin
        acc_q[k] <= '0;
      end
    end else begin
      feat_vld_o <= flush;
      if (!empty_i) begin
        lane_q <= last_lane ? '0 : lane_q + 1'b1;
      end
      // Start the next subgraph from zero
      for (int k = 0; k < NUM_FEAT; k++) begin
        acc_q[k] <= flush ? '0 : acc_d[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (flush) begin
      for (int k = 0; k < NUM_FEAT; k++) begin
        feat_data_o[k*FEAT_W +: FEAT_W] <= acc_d[k];
      end
    end
  end

endmodule

// ==== rtl/coef_fifo.sv ====
`timescale 1ns/1ps

module coef_fifo (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             push_i,
  input  logic [gat_dims_pkg::ENTRY_W-1:0] push_entry_i,
  input  logic                             pop_i,
  output logic [gat_dims_pkg::ENTRY_W-1:0] pop_entry_o,
  output logic                             empty_o,
  output logic                             afull_o
);

  import gat_dims_pkg::*;

  logic [ENTRY_W-1:0]     mem [FIFO_DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr_q;
  logic [FIFO_ADDR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0]  cnt_q;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Head word is visible without a read strobe
  assign pop_entry_o = mem[rd_ptr_q];
  assign empty_o     = (cnt_q == '0);

  // Keep room for the rows still inside the score pipeline
  assign afull_o = (FIFO_DEPTH - int'(cnt_q)) < (PIPE_SLOTS + 1);

endmodule

// ==== rtl/attn_score_unit.sv ====
`timescale 1ns/1ps

module attn_score_unit (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wh_vld_i,
  input  logic                              wh_last_i,
  input  logic                              wh_rdy_i,
  input  logic [gat_dims_pkg::WH_ROW_W-1:0] wh_data_i,
  input  logic                              a_wr_i,
  input  logic [gat_dims_pkg::A_ADDR_W-1:0] a_addr_i,
  input  logic [gat_dims_pkg::A_W-1:0]      a_data_i,
  output logic                              push_o,
  output logic [gat_dims_pkg::ENTRY_W-1:0]  push_entry_o
);

  import gat_dims_pkg::*;
  import gat_fixed_pkg::*;

  logic signed [A_W-1:0]     a_q [A_DEPTH];
  logic                      first_q;
  logic                      accept;
  logic signed [SCORE_W-1:0] src_dot;
  logic signed [SCORE_W-1:0] dst_dot;
  logic signed [SCORE_W-1:0] src_q;

  logic                      s1_vld_q;
  logic                      s1_last_q;
  logic [WH_ROW_W-1:0]       s1_row_q;
  logic signed [SCORE_W-1:0] s1_dst_q;

  // One guard bit so the sum of both halves cannot wrap
  logic signed [SCORE_W:0]   score;
  logic signed [SCORE_W:0]   leaky;
  logic signed [SCORE_W:0]   scaled;
  logic signed [COEF_W-1:0]  coef;

  assign accept = wh_vld_i & wh_rdy_i;

  always_ff @(posedge clk) begin
    if (a_wr_i) begin
      a_q[a_addr_i] <= a_data_i;
    end
  end

  // Both half dot products of the incoming row
  always_comb begin
    logic signed [WH_W-1:0] lane;
    src_dot = '0;
    dst_dot = '0;
    for (int k = 0; k < NUM_FEAT; k++) begin
      lane    = wh_data_i[k*WH_W +: WH_W];
      src_dot = src_dot + lane * a_q[k];
      dst_dot = dst_dot + lane * a_q[NUM_FEAT + k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q  <= 1'b1;
      s1_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= accept;
      if (accept) begin
        first_q <= wh_last_i;
      end
    end
  end

  // Dot-product stage
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_row_q  <= wh_data_i;
      s1_last_q <= wh_last_i;
      s1_dst_q  <= dst_dot;
      // Target node fixes the source term for the whole subgraph
      if (first_q) begin
        src_q <= src_dot;
      end
    end
  end

  // Leaky ReLU, scaling and saturation
  always_comb begin
    score  = src_q + s1_dst_q;
    leaky  = score[SCORE_W] ? (score >>> LEAKY_SHIFT) : score;
    scaled = leaky >>> SCORE_SHIFT;
    if (scaled > COEF_MAX) begin
      coef = COEF_W'(COEF_MAX);
    end else if (scaled < COEF_MIN) begin
      coef = COEF_W'(COEF_MIN);
    end else begin
      coef = scaled[COEF_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_o <= 1'b0;
    end else begin
      push_o <= s1_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld_q) begin
      push_entry_o[ENTRY_ROW_LSB +: WH_ROW_W] <= s1_row_q;
      push_entry_o[ENTRY_COEF_LSB +: COEF_W]  <= coef;
      push_entry_o[ENTRY_LAST_BIT]            <= s1_last_q;
    end
  end

endmodule

// ==== rtl/gat_fixed_pkg.sv ====
package gat_fixed_pkg;

  // Leaky ReLU slope of 1/8 for negative scores
  localparam int LEAKY_SHIFT = 3;

  // Score to coefficient scaling
  localparam int SCORE_SHIFT = 4;

  // Saturation range of a signed 8-bit coefficient
  localparam int COEF_MAX    = 127;
  localparam int COEF_MIN    = -128;

endpackage

// ==== rtl/gat_dims_pkg.sv ====
package gat_dims_pkg;

  // Feature lanes of one projected row
  localparam int NUM_FEAT    = 4;
  localparam int WH_W        = 12;
  localparam int WH_ROW_W    = NUM_FEAT * WH_W;
  localparam int LANE_W      = 2;

  // Attention vector holds the source half before the destination half
  localparam int A_W         = 8;
  localparam int A_DEPTH     = 2 * NUM_FEAT;
  localparam int A_ADDR_W    = 3;

  // Score and coefficient
  localparam int SCORE_W     = 22;
  localparam int COEF_W      = 8;

  // FIFO word holds the row, the coefficient and the last flag
  localparam int ENTRY_ROW_LSB  = 0;
  localparam int ENTRY_COEF_LSB = ENTRY_ROW_LSB + WH_ROW_W;
  localparam int ENTRY_LAST_BIT = ENTRY_COEF_LSB + COEF_W;
  localparam int ENTRY_W        = ENTRY_LAST_BIT + 1;

  // Coefficient FIFO
  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_ADDR_W = 3;
  localparam int FIFO_CNT_W  = 4;

  // Entries that can still arrive after the ready level drops
  localparam int PIPE_SLOTS  = 2;

  // Aggregated result
  localparam int FEAT_W      = 32;
  localparam int FEAT_ROW_W  = NUM_FEAT * FEAT_W;

endpackage
